// ==== common/hsk_macros.svh ====
`ifndef HSK_MACROS_SVH
`define HSK_MACROS_SVH

////////////////////
// Serial timing
////////////////////

// Clock cycles per serial bit
`define HSK_BAUD_PERIOD 160
// Cycle within a bit where the slow SURF edge has settled
`define HSK_SAMPLE_POINT 120
// Start bit, 8 data bits, stop bit
`define HSK_FRAME_BITS 10

////////////////////
// Widths and depths
////////////////////

// Flops in each input synchronizer
`define HSK_SYNC_STAGES 2
// Crate bus byte counter width
`define HSK_COUNT_WIDTH 8

`endif

// ==== common/hsk_pkg.sv ====
`include "hsk_macros.svh"

package hsk_pkg;

    // Frames seen going out on the crate bus
    // Wraps silently past the top count
    typedef logic [`HSK_COUNT_WIDTH-1:0] rx_bytes_t;

    // Frame tracking for the retimer and the byte counter
    typedef enum logic {
        FRAME_IDLE = 1'b0,
        FRAME_BUSY = 1'b1
    } frame_state_t;

endpackage

// ==== verilog/uart_retime.sv ====
`timescale 1ns/1ps
`include "hsk_macros.svh"

module uart_retime
    import hsk_pkg::*;
(
    input  logic init_clk,
    input  logic rst_i,
    input  logic surf_tx_i,
    output logic surf_retimed_o
);

    localparam int CYC_W = $clog2(`HSK_BAUD_PERIOD);
    localparam int BIT_W = $clog2(`HSK_FRAME_BITS);

    // Open-drain line, slow rising edge
    logic [`HSK_SYNC_STAGES-1:0] surf_sync;
    logic                        surf_prev;
    logic                        surf_line;
    logic                        start_edge;

    frame_state_t                state;
    logic [CYC_W-1:0]            cyc_cnt;
    logic [BIT_W-1:0]            bit_cnt;

    assign surf_line  = surf_sync[`HSK_SYNC_STAGES-1];
    // Falling edges are fast, so the start bit is a clean reference
    assign start_edge = surf_prev & ~surf_line;

    // Input synchronizer plus one stage for the edge detect
    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            surf_sync <= '1;
            surf_prev <= 1'b1;
        end else begin
            surf_sync <= {surf_sync[`HSK_SYNC_STAGES-2:0], surf_tx_i};
            surf_prev <= surf_line;
        end
    end

    ////////////////////
    // Bit timing
    ////////////////////

    // cyc_cnt holds cycles since the start edge, modulo one bit
    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            state          <= FRAME_IDLE;
            cyc_cnt        <= '0;
            bit_cnt        <= '0;
            surf_retimed_o <= 1'b1;
        end else begin
            case (state)
                FRAME_IDLE: begin
                    surf_retimed_o <= 1'b1;
                    if (start_edge) begin
                        state   <= FRAME_BUSY;
                        cyc_cnt <= CYC_W'(1);
                        bit_cnt <= '0;
                    end
                end
                default: begin
                    // Advance one bit period
                    if (cyc_cnt == CYC_W'(`HSK_BAUD_PERIOD - 1)) begin
                        cyc_cnt <= '0;
                        bit_cnt <= bit_cnt + BIT_W'(1);
                    end else begin
                        cyc_cnt <= cyc_cnt + CYC_W'(1);
                    end
                    // Late sample, held until the next one
                    if (cyc_cnt == CYC_W'(`HSK_SAMPLE_POINT)) begin
                        if (bit_cnt == BIT_W'(`HSK_FRAME_BITS - 1)) begin
                            // Stop bit, force idle level even on a framing error
                            surf_retimed_o <= 1'b1;
                            state          <= FRAME_IDLE;
                        end else begin
                            surf_retimed_o <= surf_line;
                        end
                    end
                end
            endcase
        end
    end

    // Idle retimer never pulls the reply line low
    a_idle_high : assert property (
        @(posedge init_clk) disable iff (rst_i)
        (state == FRAME_IDLE) |-> surf_retimed_o
    );

endmodule

// ==== verilog/hskbus_merge.sv ====
`timescale 1ns/1ps
`include "hsk_macros.svh"

module hskbus_merge
    import hsk_pkg::*;
(
    input  logic      init_clk,
    input  logic      rst_i,
    input  logic      hskbus_tx_i,
    output logic      hskbus_rx_o,
    input  logic      surf_retimed_i,
    output logic      surf_rx_o,
    input  logic      hsk_tx_i,
    output logic      hsk_rx_o,
    input  logic      crate_enable_user_i,
    input  logic      crate_enable_hsk_i,
    output rx_bytes_t hskbus_rx_bytes_o
);

    localparam int FRAME_CYCLES = `HSK_FRAME_BITS * `HSK_BAUD_PERIOD;
    localparam int BUSY_W       = $clog2(FRAME_CYCLES);

    // Either the user or the housekeeping processor can open the crate
    logic              crate_enable;
    logic              surf_reply;

    // Frame detector
    frame_state_t      fd_state;
    logic [BUSY_W-1:0] fd_cnt;
    logic              tx_prev;
    logic              tx_fall;

    assign crate_enable = crate_enable_user_i | crate_enable_hsk_i;
    // Closed crate looks like an idle SURF
    assign surf_reply   = crate_enable ? surf_retimed_i : 1'b1;
    assign tx_fall      = tx_prev & ~hskbus_tx_i;

    ////////////////////
    // Fan-out and merge
    ////////////////////

    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            surf_rx_o   <= 1'b1;
            hsk_rx_o    <= 1'b1;
            hskbus_rx_o <= 1'b1;
        end else begin
            // Local processor always listens
            hsk_rx_o    <= hskbus_tx_i;
            surf_rx_o   <= crate_enable ? hskbus_tx_i : 1'b1;
            // Wired-AND of the idle-high replies
            hskbus_rx_o <= hsk_tx_i & surf_reply;
        end
    end

    ////////////////////
    // Byte counter
    ////////////////////

    // One count per start edge, then blind for a whole frame
    // so data bits do not retrigger
    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            tx_prev           <= 1'b1;
            fd_state          <= FRAME_IDLE;
            fd_cnt            <= '0;
            hskbus_rx_bytes_o <= '0;
        end else begin
            tx_prev <= hskbus_tx_i;
            case (fd_state)
                FRAME_IDLE: begin
                    if (tx_fall) begin
                        fd_state          <= FRAME_BUSY;
                        fd_cnt            <= BUSY_W'(1);
                        hskbus_rx_bytes_o <= hskbus_rx_bytes_o + rx_bytes_t'(1);
                    end
                end
                default: begin
                    if (fd_cnt == BUSY_W'(FRAME_CYCLES - 1)) begin
                        fd_state <= FRAME_IDLE;
                        fd_cnt   <= '0;
                    end else begin
                        fd_cnt <= fd_cnt + BUSY_W'(1);
                    end
                end
            endcase
        end
    end

    // SURFs see an idle line one cycle after the crate closes
    a_surf_gated : assert property (
        @(posedge init_clk) disable iff (rst_i)
        !crate_enable |=> surf_rx_o
    );

endmodule

// ==== verilog/uart_router.sv ====
`timescale 1ns/1ps
`include "hsk_macros.svh"

module uart_router (
    input  logic init_clk,
    input  logic rst_i,
    input  logic dbg_rx_i,
    output logic dbg_tx_o,
    input  logic trx_i,
    input  logic tctrl_b_i,
    output logic f_ttx_o,
    output logic boardman_rx_o,
    input  logic boardman_tx_i,
    input  logic hskbus_local_i,
    output logic hskbus_tx_o,
    input  logic hskbus_rx_i
);

    // Bit 0 dbg_rx, bit 1 trx, bit 2 tctrl_b
    logic [2:0] in_sync [`HSK_SYNC_STAGES];
    logic       dbg_rx_s;
    logic       trx_s;
    logic       tctrl_b_s;

    // External lines, all idle high
    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            for (int i = 0; i < `HSK_SYNC_STAGES; i++) begin
                in_sync[i] <= '1;
            end
        end else begin
            in_sync[0] <= {tctrl_b_i, trx_i, dbg_rx_i};
            for (int i = 1; i < `HSK_SYNC_STAGES; i++) begin
                in_sync[i] <= in_sync[i-1];
            end
        end
    end

    assign dbg_rx_s  = in_sync[`HSK_SYNC_STAGES-1][0];
    assign trx_s     = in_sync[`HSK_SYNC_STAGES-1][1];
    assign tctrl_b_s = in_sync[`HSK_SYNC_STAGES-1][2];

    // Crate bus source, TURF only while it holds TCTRL_B low
    assign hskbus_tx_o = hskbus_local_i ? dbg_rx_s : (tctrl_b_s | trx_s);

    // Outward lines, detached paths park at idle
    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            dbg_tx_o      <= 1'b1;
            boardman_rx_o <= 1'b1;
            f_ttx_o       <= 1'b1;
        end else begin
            dbg_tx_o      <= hskbus_local_i ? hskbus_rx_i : boardman_tx_i;
            boardman_rx_o <= hskbus_local_i ? 1'b1 : dbg_rx_s;
            f_ttx_o       <= hskbus_local_i ? 1'b1 : hskbus_rx_i;
        end
    end

    // TURF hears nothing while the debug port owns the bus
    a_local_turf_idle : assert property (
        @(posedge init_clk) disable iff (rst_i)
        hskbus_local_i |=> f_ttx_o
    );

endmodule

// ==== verilog/hsk_uart_top.sv ====
`timescale 1ns/1ps

module hsk_uart_top
    import hsk_pkg::*;
(
    input  logic      init_clk,
    input  logic      rst_i,
    // Debug port
    input  logic      dbg_rx_i,
    output logic      dbg_tx_o,
    // TURF serial path
    input  logic      trx_i,
    input  logic      tctrl_b_i,
    output logic      f_ttx_o,
    // Board manager UART
    output logic      boardman_rx_o,
    input  logic      boardman_tx_i,
    // SURF crate lines
    input  logic      surf_tx_i,
    output logic      surf_rx_o,
    // Local housekeeping processor
    input  logic      hsk_tx_i,
    output logic      hsk_rx_o,
    // Mode controls
    input  logic      hskbus_local_i,
    input  logic      crate_enable_user_i,
    input  logic      crate_enable_hsk_i,
    output rx_bytes_t hskbus_rx_bytes_o
);

    // Toward the crate
    logic hskbus_tx;
    // Merged replies
    logic hskbus_rx;
    // SURF reply after late sampling
    logic surf_retimed;

    ////////////////////
    // Input side
    ////////////////////

    uart_retime u_retime (
        .init_clk       (init_clk),
        .rst_i          (rst_i),
        .surf_tx_i      (surf_tx_i),
        .surf_retimed_o (surf_retimed)
    );

    ////////////////////
    // Bus merge
    ////////////////////

    hskbus_merge u_merge (
        .init_clk            (init_clk),
        .rst_i               (rst_i),
        .hskbus_tx_i         (hskbus_tx),
        .hskbus_rx_o         (hskbus_rx),
        .surf_retimed_i      (surf_retimed),
        .surf_rx_o           (surf_rx_o),
        .hsk_tx_i            (hsk_tx_i),
        .hsk_rx_o            (hsk_rx_o),
        .crate_enable_user_i (crate_enable_user_i),
        .crate_enable_hsk_i  (crate_enable_hsk_i),
        .hskbus_rx_bytes_o   (hskbus_rx_bytes_o)
    );

    // Routing between debug, TURF and board manager
    uart_router u_router (
        .init_clk       (init_clk),
        .rst_i          (rst_i),
        .dbg_rx_i       (dbg_rx_i),
        .dbg_tx_o       (dbg_tx_o),
        .trx_i          (trx_i),
        .tctrl_b_i      (tctrl_b_i),
        .f_ttx_o        (f_ttx_o),
        .boardman_rx_o  (boardman_rx_o),
        .boardman_tx_i  (boardman_tx_i),
        .hskbus_local_i (hskbus_local_i),
        .hskbus_tx_o    (hskbus_tx),
        .hskbus_rx_i    (hskbus_rx)
    );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    // Free-running clock, 50% duty
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Synchronous reset, released just after an edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// ==== verif/tb_hsk_uart.sv ====
`timescale 1ns/1ps
`include "hsk_macros.svh"

module tb_hsk_uart;

    localparam int          CLK_PERIOD_NS = 40;
    localparam int          RESET_CYCLES  = 8;
    localparam logic [16:0] LFSR_SEED     = 17'd88032;
    localparam int          BIT_CYCLES    = `HSK_BAUD_PERIOD;
    localparam int          FRAME_CYCLES  = `HSK_FRAME_BITS * `HSK_BAUD_PERIOD;
    // Retimed SURF path lags by most of a bit
    localparam int          EDGE_WAIT     = 2 * BIT_CYCLES;
    localparam int          WATCH_CYCLES  = FRAME_CYCLES + 2 * BIT_CYCLES;
    localparam int          SETTLE_CYCLES = 4;

    // Source codes used in the stimulus file
    localparam int SRC_DBG  = 0;
    localparam int SRC_TRX  = 1;
    localparam int SRC_BMAN = 2;
    localparam int SRC_HSK  = 3;

    typedef struct packed {
        logic        local_mode;
        logic        en_user;
        logic        en_hsk;
        logic        tctrl_b;
        logic [3:0]  src;
        logic [7:0]  data;
        logic [4:0]  dest;
        logic [15:0] reps;
    } stim_rec_t;

    logic init_clk;
    logic rst;
    logic dbg_rx;
    logic dbg_tx;
    logic trx;
    logic tctrl_b;
    logic f_ttx;
    logic boardman_rx;
    logic boardman_tx;
    logic surf_tx;
    logic surf_rx;
    logic hsk_tx;
    logic hsk_rx;
    logic hskbus_local;
    logic crate_en_user;
    logic crate_en_hsk;
    logic [`HSK_COUNT_WIDTH-1:0] rx_bytes;

    // Watched lines, index matches the dest mask bits
    logic [4:0]  out_lines;
    stim_rec_t   records[$];
    logic [16:0] lfsr_state;
    bit          stim_loaded;
    int          total_frames;
    longint      timeout_cycles;
    int          checks;
    int          check_errors;
    int          frame_errors;
    int          load_errors;

    assign out_lines = {hsk_rx, surf_rx, boardman_rx, f_ttx, dbg_tx};

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk_o (init_clk),
        .rst_o (rst)
    );

    hsk_uart_top DUT (
        .init_clk            (init_clk),
        .rst_i               (rst),
        .dbg_rx_i            (dbg_rx),
        .dbg_tx_o            (dbg_tx),
        .trx_i               (trx),
        .tctrl_b_i           (tctrl_b),
        .f_ttx_o             (f_ttx),
        .boardman_rx_o       (boardman_rx),
        .boardman_tx_i       (boardman_tx),
        .surf_tx_i           (surf_tx),
        .surf_rx_o           (surf_rx),
        .hsk_tx_i            (hsk_tx),
        .hsk_rx_o            (hsk_rx),
        .hskbus_local_i      (hskbus_local),
        .crate_enable_user_i (crate_en_user),
        .crate_enable_hsk_i  (crate_en_hsk),
        .hskbus_rx_bytes_o   (rx_bytes)
    );

    ////////////////////
    // Helpers
    ////////////////////

    // x^17 + x^14 + 1, maximal length
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_random(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic string line_name(input int idx);
        case (idx)
            0:       return "dbg_tx_o";
            1:       return "f_ttx_o";
            2:       return "boardman_rx_o";
            3:       return "surf_rx_o";
            default: return "hsk_rx_o";
        endcase
    endfunction

    task automatic drive_source(input int src, input logic level);
        case (src)
            SRC_DBG:  dbg_rx = level;
            SRC_TRX:  trx = level;
            SRC_BMAN: boardman_tx = level;
            SRC_HSK:  hsk_tx = level;
            default:  surf_tx = level;
        endcase
    endtask

    // Start, 8 data bits LSB first, stop; entered at posedge plus 1 ns
    task automatic send_frame(input int src, input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int b = 0; b < `HSK_FRAME_BITS; b++) begin
            drive_source(src, frame[b]);
            repeat (BIT_CYCLES) @(posedge init_clk);
            #1;
        end
    endtask

    // Lock on the start edge, then sample each bit in its middle
    task automatic receive_frame(input int idx, input logic [7:0] data);
        int         waited;
        logic       start_bit;
        logic       stop_bit;
        logic [7:0] got;
        waited = 0;
        got    = '0;
        @(negedge init_clk);
        while (out_lines[idx] !== 1'b0 && waited < EDGE_WAIT) begin
            @(negedge init_clk);
            waited++;
        end
        if (out_lines[idx] !== 1'b0) begin
            $display("ERROR: no frame arrived on %s within %0d cycles", line_name(idx), EDGE_WAIT);
            frame_errors++;
        end else begin
            repeat (BIT_CYCLES / 2) @(negedge init_clk);
            start_bit = out_lines[idx];
            for (int b = 0; b < 8; b++) begin
                repeat (BIT_CYCLES) @(negedge init_clk);
                got[b] = out_lines[idx];
            end
            repeat (BIT_CYCLES) @(negedge init_clk);
            stop_bit = out_lines[idx];
            checks++;
            if (start_bit !== 1'b0) begin
                $display("CHECK FAILED: %s start bit 0x%h, expected 0x0", line_name(idx), start_bit);
                check_errors++;
            end
            if (got !== data) begin
                $display("CHECK FAILED: %s data 0x%02h, expected 0x%02h", line_name(idx), got, data);
                check_errors++;
            end
            if (stop_bit !== 1'b1) begin
                $display("CHECK FAILED: %s stop bit 0x%h, expected 0x1", line_name(idx), stop_bit);
                check_errors++;
            end
        end
    endtask

    // Line not routed from the source, must never leave idle
    task automatic hold_idle(input int idx);
        bit seen_low;
        seen_low = 1'b0;
        for (int c = 0; c < WATCH_CYCLES; c++) begin
            @(negedge init_clk);
            if (!seen_low && out_lines[idx] !== 1'b1) begin
                seen_low = 1'b1;
                $display("CHECK FAILED: %s 0x%h, expected 0x1 (idle)", line_name(idx),
                         out_lines[idx]);
                check_errors++;
            end
        end
        checks++;
    endtask

    task automatic watch_line(input int idx, input bit expect_frame, input logic [7:0] data);
        if (expect_frame) begin
            receive_frame(idx, data);
        end else begin
            hold_idle(idx);
        end
    endtask

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin : watchdog
        wait (stim_loaded);
        repeat (timeout_cycles) @(posedge init_clk);
        $display("ERROR: run exceeded %0d cycles and was stopped", timeout_cycles);
        $display("Test failures found");
        $finish;
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin : main
        int          fd;
        int          fields;
        int          status;
        int          rnd;
        int          v_local;
        int          v_user;
        int          v_hsk;
        int          v_tctrl;
        int          v_src;
        int          v_byte;
        int          v_mask;
        int          v_reps;
        string       text;
        stim_rec_t   rec;
        logic [7:0]  tx_byte;
        logic [7:0]  exp_count;
        bit          on_bus;
        // Idle lines, detached mode, crate closed
        dbg_rx        = 1'b1;
        trx           = 1'b1;
        tctrl_b       = 1'b1;
        boardman_tx   = 1'b1;
        surf_tx       = 1'b1;
        hsk_tx        = 1'b1;
        hskbus_local  = 1'b0;
        crate_en_user = 1'b0;
        crate_en_hsk  = 1'b0;
        lfsr_state    = LFSR_SEED;
        checks        = 0;
        check_errors  = 0;
        frame_errors  = 0;
        load_errors   = 0;
        total_frames  = 0;
        exp_count     = '0;
        fd = $fopen("verif/hsk_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: stimulus file could not be opened");
            load_errors++;
        end else begin
            while (!$feof(fd)) begin
                status = $fgets(text, fd);
                // Skip blank and comment lines
                if (status > 0 && text.len() > 1 && text.getc(0) != "#") begin
                    fields = $sscanf(text, "%h %h %h %h %h %h %h %h", v_local, v_user, v_hsk,
                                     v_tctrl, v_src, v_byte, v_mask, v_reps);
                    if (fields == 8) begin
                        rec.local_mode = v_local[0];
                        rec.en_user    = v_user[0];
                        rec.en_hsk     = v_hsk[0];
                        rec.tctrl_b    = v_tctrl[0];
                        rec.src        = v_src[3:0];
                        rec.data       = v_byte[7:0];
                        rec.dest       = v_mask[4:0];
                        rec.reps       = v_reps[15:0];
                        records.push_back(rec);
                        total_frames += v_reps;
                    end
                end
            end
            $fclose(fd);
        end
        if (records.size() == 0) begin
            $display("ERROR: no stimulus records were loaded");
            load_errors++;
        end
        // 12 frame times per frame sent, plus reset
        timeout_cycles = longint'(total_frames * 12 + 1) * longint'(FRAME_CYCLES)
                       + longint'(RESET_CYCLES);
        stim_loaded = 1'b1;

        // Reset state
        wait (rst === 1'b0);
        @(negedge init_clk);
        for (int i = 0; i < 5; i++) begin
            if (out_lines[i] !== 1'b1) begin
                $display("CHECK FAILED: %s 0x%h after reset, expected 0x1", line_name(i),
                         out_lines[i]);
                check_errors++;
            end
        end
        if (rx_bytes !== 8'h00) begin
            $display("CHECK FAILED: hskbus_rx_bytes_o 0x%02h after reset, expected 0x00", rx_bytes);
            check_errors++;
        end

        foreach (records[r]) begin
            rec = records[r];
            @(posedge init_clk);
            #1;
            hskbus_local  = rec.local_mode;
            crate_en_user = rec.en_user;
            crate_en_hsk  = rec.en_hsk;
            tctrl_b       = rec.tctrl_b;
            // Let tctrl_b through its synchronizer
            repeat (SETTLE_CYCLES) @(posedge init_clk);
            #1;
            // Only the debug line in local mode, or the TURF with tctrl_b low, feeds the bus
            on_bus = (rec.local_mode && int'(rec.src) == SRC_DBG)
                  || (!rec.local_mode && !rec.tctrl_b && int'(rec.src) == SRC_TRX);
            for (int k = 0; k < int'(rec.reps); k++) begin
                if (k == 0) begin
                    tx_byte = rec.data;
                end else begin
                    take_random(8, rnd);
                    tx_byte = rnd[7:0];
                end
                fork
                    send_frame(int'(rec.src), tx_byte);
                    watch_line(0, rec.dest[0], tx_byte);
                    watch_line(1, rec.dest[1], tx_byte);
                    watch_line(2, rec.dest[2], tx_byte);
                    watch_line(3, rec.dest[3], tx_byte);
                    watch_line(4, rec.dest[4], tx_byte);
                join
                if (on_bus) begin
                    exp_count = exp_count + 8'd1;
                end
                @(negedge init_clk);
                checks++;
                if (rx_bytes !== exp_count) begin
                    $display("CHECK FAILED: hskbus_rx_bytes_o 0x%02h, expected 0x%02h (record %0d)",
                             rx_bytes, exp_count, r);
                    check_errors++;
                end
                // Random idle gap between frames
                take_random(8, rnd);
                repeat (8 + rnd) @(posedge init_clk);
                #1;
            end
        end

        $display("Done: %0d checks, %0d value errors, %0d missing frames, %0d load errors",
                 checks, check_errors, frame_errors, load_errors);
        if (check_errors == 0 && frame_errors == 0 && load_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verif/hsk_stimulus.txt ====
# local en_user en_hsk tctrl_b src byte dest reps (all hex)
# src 0 dbg_rx 1 trx 2 boardman_tx 3 hsk_tx 4 surf_tx; dest bits 0 dbg_tx 1 f_ttx 2 boardman_rx 3 surf_rx 4 hsk_rx
1 1 0 1 0 a5 18 1
1 1 0 1 3 3c 01 1
1 0 1 1 4 c3 01 1
1 1 0 1 2 99 00 1
0 1 0 0 1 5a 18 1
0 1 0 0 4 96 02 1
0 1 0 0 0 e1 04 1
0 1 0 0 2 7e 01 1
0 1 0 0 3 c7 02 1
0 1 0 1 1 81 00 1
0 0 1 1 1 ff 00 1
0 0 0 0 4 69 00 1
0 0 0 0 1 ab 10 1
1 0 0 1 0 12 10 1
1 0 0 1 3 34 01 1
1 0 0 1 4 55 00 1
0 0 1 0 4 00 02 1
1 1 0 1 4 f0 01 1
1 0 1 1 0 0f 18 1
0 1 1 0 1 00 18 100

// ==== verilog.f ====
+incdir+common
common/hsk_pkg.sv
verilog/uart_retime.sv
verilog/hskbus_merge.sv
verilog/uart_router.sv
verilog/hsk_uart_top.sv
verif/tb_clock.sv
verif/tb_hsk_uart.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_hsk_uart
LINT_TOP   := hsk_uart_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
PASS_TEXT  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
